// File: rtl/u712Pkg.sv
// Shared types and sizes for the chip RAM byte-lane path, imported by every RTL block
`default_nettype none

package u712Pkg;

    ////////////////////////////////////////////////////////////////////
    // Chip RAM dimensions
    ////////////////////////////////////////////////////////////////////

    // Chip RAM is word addressed, one word per 32-bit location
    localparam int CHIP_ADDR_W = 8;
    localparam int CHIP_WORDS  = 1 << CHIP_ADDR_W;

    // Full 68040 data bus and the Agnus half-word
    localparam int DATA_W = 32;
    localparam int HALF_W = 16;

    ////////////////////////////////////////////////////////////////////
    // 68040 transfer attributes
    ////////////////////////////////////////////////////////////////////

    // SIZ1:SIZ0 as the 68040 drives them on the bus
    typedef enum logic [1:0] {
        SIZ_LONG = 2'b00,
        SIZ_BYTE = 2'b01,
        SIZ_WORD = 2'b10,
        SIZ_LINE = 2'b11
    } sizeE;

    // Active-high byte lanes, big-endian as on the 68040 bus
    // Field uu is bits 31..24 and ll is bits 7..0
    typedef struct packed {
        logic uu;
        logic um;
        logic lm;
        logic ll;
    } laneMaskT;

    ////////////////////////////////////////////////////////////////////
    // Master requests and the array command
    ////////////////////////////////////////////////////////////////////

    // CPU request as captured on ts
    typedef struct packed {
        logic [CHIP_ADDR_W-1:0] addr;
        logic [1:0]             a;
        sizeE                   siz;
        logic                   rnw;
        logic [DATA_W-1:0]      wdata;
    } cpuReqT;

    // DMA request as captured on dmaStart
    // The column strobes are kept active high inside the controller
    typedef struct packed {
        logic [CHIP_ADDR_W-1:0] addr;
        logic                   rnw;
        logic                   casU;
        logic                   casL;
        logic                   dbEn;
        logic [HALF_W-1:0]      wdata;
    } dmaReqT;

    // One chip RAM access, lanes only matter when we is set
    typedef struct packed {
        logic [CHIP_ADDR_W-1:0] addr;
        laneMaskT               lanes;
        logic                   we;
        logic [DATA_W-1:0]      wdata;
    } memCmdT;

endpackage

`default_nettype wire

// File: rtl/byteEnable.sv
// Byte-lane decode for the 32-bit bus and for chip RAM, driven by the chip RAM sequencer
`default_nettype none

module byteEnable
    import u712Pkg::*;
(
    input  cpuReqT   cpuReq,
    input  dmaReqT   dmaReq,
    input  logic     dmaCycle,
    output laneMaskT busLanes,
    output laneMaskT chipLanes
);

    // Lanes asked for by the Agnus column strobes
    laneMaskT dmaLanes;

    ////////////////////////////////////////////////////////////////////
    // 32-bit bus byte enables
    ////////////////////////////////////////////////////////////////////

    // Reads always take the whole long word and the CPU picks its bytes
    // Writes only touch the bytes that SIZ and A[1:0] point at
    always_comb begin
        busLanes = '{uu: 1'b1, um: 1'b1, lm: 1'b1, ll: 1'b1};
        if (!cpuReq.rnw) begin
            unique case (cpuReq.siz)
                SIZ_BYTE: begin
                    // Offset 0 is the most significant byte on the 68040
                    busLanes.uu = (cpuReq.a == 2'd0);
                    busLanes.um = (cpuReq.a == 2'd1);
                    busLanes.lm = (cpuReq.a == 2'd2);
                    busLanes.ll = (cpuReq.a == 2'd3);
                end
                SIZ_WORD: begin
                    // Only A1 matters for a word, A0 is ignored
                    busLanes.uu = !cpuReq.a[1];
                    busLanes.um = !cpuReq.a[1];
                    busLanes.lm = cpuReq.a[1];
                    busLanes.ll = cpuReq.a[1];
                end
                default: begin
                    // Long word and line transfers use every lane
                    busLanes = '{uu: 1'b1, um: 1'b1, lm: 1'b1, ll: 1'b1};
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Chip RAM byte enables
    ////////////////////////////////////////////////////////////////////

    // Agnus works on a 16-bit half of the RAM word picked by dbEn
    // casU is the high byte of that half and casL the low byte
    always_comb begin
        dmaLanes.uu = dmaReq.casU && dmaReq.dbEn;
        dmaLanes.um = dmaReq.casL && dmaReq.dbEn;
        dmaLanes.lm = dmaReq.casU && !dmaReq.dbEn;
        dmaLanes.ll = dmaReq.casL && !dmaReq.dbEn;
    end

    // Chip RAM follows the strobes during DMA and the CPU lanes otherwise
    assign chipLanes = dmaCycle ? dmaLanes : busLanes;

endmodule

`default_nettype wire

// File: rtl/chipRamSequencer.sv
// Arbiter and access sequencer for chip RAM, granting DMA ahead of the CPU and returning ta and dmaDone
`default_nettype none

module chipRamSequencer
    import u712Pkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    input  logic              ts,
    input  cpuReqT            cpuReq,
    input  logic              dmaStart,
    input  dmaReqT            dmaReq,
    input  laneMaskT          chipLanes,
    input  logic [DATA_W-1:0] memRdata,
    output cpuReqT            heldCpuReq,
    output dmaReqT            heldDmaReq,
    output logic              dmaCycle,
    output memCmdT            memCmd,
    output logic              ta,
    output logic [DATA_W-1:0] cpuRdata,
    output logic              dmaDone,
    output logic [HALF_W-1:0] dmaRdata
);

    // ACCESS is the cycle memCmd is live, ACK is the acknowledge cycle
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        ACCESS = 2'd1,
        ACK    = 2'd2
    } seqStateE;

    seqStateE state;

    // One outstanding request per master
    logic cpuPend;
    logic dmaPend;

    // Set while the access in flight belongs to the DMA engine
    logic ownerDma;

    // Issue decision for the coming edge
    logic issueSlot;
    logic issueDma;
    logic issueCpu;
    logic issue;

    // Registered command fields, packed into memCmd below
    logic [CHIP_ADDR_W-1:0] cmdAddr;
    laneMaskT               cmdLanes;
    logic                   cmdWe;
    logic [DATA_W-1:0]      cmdWdata;

    ////////////////////////////////////////////////////////////////////
    // Request capture
    ////////////////////////////////////////////////////////////////////

    // Each master holds its request still until acknowledged, so the
    // held copy stays valid through the ACK cycle
    always_ff @(posedge clk) begin
        if (ts) begin
            heldCpuReq <= cpuReq;
        end
        if (dmaStart) begin
            heldDmaReq <= dmaReq;
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////////////

    // A new access can start from IDLE or straight out of ACK
    assign issueSlot = (state != ACCESS);
    assign issueDma  = issueSlot && dmaPend;
    assign issueCpu  = issueSlot && !dmaPend && cpuPend;
    assign issue     = issueDma || issueCpu;

    // The byte-lane decode looks at the master about to be issued,
    // and at the current owner while an access is running
    assign dmaCycle = issueSlot ? dmaPend : ownerDma;

    ////////////////////////////////////////////////////////////////////
    // Access state machine
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state    <= IDLE;
            cpuPend  <= 1'b0;
            dmaPend  <= 1'b0;
            ownerDma <= 1'b0;
            ta       <= 1'b0;
            dmaDone  <= 1'b0;
            cmdWe    <= 1'b0;
            cmdLanes <= '0;
        end else begin
            // Acknowledges and the command strobes last a single cycle
            ta       <= 1'b0;
            dmaDone  <= 1'b0;
            cmdWe    <= 1'b0;
            cmdLanes <= '0;

            // A start pulse never meets the clear of its own master
            if (ts) begin
                cpuPend <= 1'b1;
            end else if (issueCpu) begin
                cpuPend <= 1'b0;
            end
            if (dmaStart) begin
                dmaPend <= 1'b1;
            end else if (issueDma) begin
                dmaPend <= 1'b0;
            end

            unique case (state)
                ACCESS: begin
                    // Array data is registered on this edge, so the
                    // acknowledge lines up with it
                    state <= ACK;
                    if (ownerDma) begin
                        dmaDone <= 1'b1;
                    end else begin
                        ta <= 1'b1;
                    end
                end
                default: begin
                    if (issue) begin
                        state    <= ACCESS;
                        ownerDma <= issueDma;
                        cmdWe    <= issueDma ? !heldDmaReq.rnw : !heldCpuReq.rnw;
                        cmdLanes <= chipLanes;
                    end else begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // Address and data only matter while cmdWe or the read is live
    always_ff @(posedge clk) begin
        if (issue) begin
            cmdAddr  <= issueDma ? heldDmaReq.addr : heldCpuReq.addr;
            // The half-word goes on both halves, the lanes pick the real one
            cmdWdata <= issueDma ? {heldDmaReq.wdata, heldDmaReq.wdata} : heldCpuReq.wdata;
        end
    end

    assign memCmd = '{addr: cmdAddr, lanes: cmdLanes, we: cmdWe, wdata: cmdWdata};

    ////////////////////////////////////////////////////////////////////
    // Read data steering
    ////////////////////////////////////////////////////////////////////

    // The CPU takes the whole word, the DMA engine its selected half
    assign cpuRdata = memRdata;
    assign dmaRdata = heldDmaReq.dbEn ? memRdata[DATA_W-1:HALF_W] : memRdata[HALF_W-1:0];

endmodule

`default_nettype wire

// File: rtl/chipRamArray.sv
// Word-wide chip RAM model with per-byte write enables and a registered read, fed by the sequencer
`default_nettype none

module chipRamArray
    import u712Pkg::*;
(
    input  logic              clk,
    input  memCmdT            memCmd,
    output logic [DATA_W-1:0] memRdata
);

    // 256 long words of chip RAM
    logic [DATA_W-1:0] mem [CHIP_WORDS];

    ////////////////////////////////////////////////////////////////////
    // Byte-lane write
    ////////////////////////////////////////////////////////////////////

    // Each lane is its own byte column, like the four byte enables of
    // the SDRAM on the real board
    always_ff @(posedge clk) begin
        if (memCmd.we) begin
            if (memCmd.lanes.uu) begin
                mem[memCmd.addr][31:24] <= memCmd.wdata[31:24];
            end
            if (memCmd.lanes.um) begin
                mem[memCmd.addr][23:16] <= memCmd.wdata[23:16];
            end
            if (memCmd.lanes.lm) begin
                mem[memCmd.addr][15:8] <= memCmd.wdata[15:8];
            end
            if (memCmd.lanes.ll) begin
                mem[memCmd.addr][7:0] <= memCmd.wdata[7:0];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Registered read
    ////////////////////////////////////////////////////////////////////

    // The addressed word is sampled on every edge
    // On a write this returns the contents before the write
    always_ff @(posedge clk) begin
        memRdata <= mem[memCmd.addr];
    end

endmodule

`default_nettype wire

// File: rtl/u712ChipRamTop.sv
// Top of the chip RAM byte-lane path, joining the CPU and DMA ports to the sequencer, decode and array
`default_nettype none

module u712ChipRamTop
    import u712Pkg::*;
(
    input  logic              clk,
    input  logic              rstN,
    // 68040 side
    input  logic              ts,
    input  cpuReqT            cpuReq,
    output logic              ta,
    output logic [DATA_W-1:0] cpuRdata,
    // Agnus side
    input  logic              dmaStart,
    input  dmaReqT            dmaReq,
    output logic              dmaDone,
    output logic [HALF_W-1:0] dmaRdata
);

    // Requests held by the sequencer for the lane decode
    cpuReqT            heldCpuReq;
    dmaReqT            heldDmaReq;
    logic              dmaCycle;

    // Chip RAM lanes back from the decode
    laneMaskT          chipLanes;

    // Array command and read word
    memCmdT            memCmd;
    logic [DATA_W-1:0] memRdata;

    ////////////////////////////////////////////////////////////////////
    // Arbitration and sequencing
    ////////////////////////////////////////////////////////////////////

    chipRamSequencer uSequencer (
        .clk        (clk),
        .rstN       (rstN),
        .ts         (ts),
        .cpuReq     (cpuReq),
        .dmaStart   (dmaStart),
        .dmaReq     (dmaReq),
        .chipLanes  (chipLanes),
        .memRdata   (memRdata),
        .heldCpuReq (heldCpuReq),
        .heldDmaReq (heldDmaReq),
        .dmaCycle   (dmaCycle),
        .memCmd     (memCmd),
        .ta         (ta),
        .cpuRdata   (cpuRdata),
        .dmaDone    (dmaDone),
        .dmaRdata   (dmaRdata)
    );

    ////////////////////////////////////////////////////////////////////
    // Byte-lane decode
    ////////////////////////////////////////////////////////////////////

    // The bus lanes feed the external 32-bit bus, which is outside
    // this path, so only the chip RAM lanes are used here
    byteEnable uByteEnable (
        .cpuReq    (heldCpuReq),
        .dmaReq    (heldDmaReq),
        .dmaCycle  (dmaCycle),
        .busLanes  (),
        .chipLanes (chipLanes)
    );

    ////////////////////////////////////////////////////////////////////
    // Chip RAM
    ////////////////////////////////////////////////////////////////////

    chipRamArray uChipRam (
        .clk      (clk),
        .memCmd   (memCmd),
        .memRdata (memRdata)
    );

endmodule

`default_nettype wire

// File: dv/u712ChipRamTb.sv
// Self-checking testbench for the chip RAM byte-lane path, run as the simulation top
`default_nettype none

module u712ChipRamTb
    import u712Pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;
    localparam logic MASTER_CPU = 1'b0;
    localparam logic MASTER_DMA = 1'b1;

    // A collision step starts both masters on the same edge to one word
    typedef enum logic [1:0] {
        OP_WRITE   = 2'd0,
        OP_READ    = 2'd1,
        OP_COLLIDE = 2'd2
    } opE;

    typedef struct packed {
        opE                     op;
        logic                   isDma;
        logic [CHIP_ADDR_W-1:0] addr;
        logic [1:0]             a;
        sizeE                   siz;
        logic                   casU;
        logic                   casL;
        logic                   dbEn;
        logic [DATA_W-1:0]      data;
    } stepT;

    logic              clk;
    logic              rstN;
    logic              ts;
    cpuReqT            cpuReq;
    logic              ta;
    logic [DATA_W-1:0] cpuRdata;
    logic              dmaStart;
    dmaReqT            dmaReq;
    logic              dmaDone;
    logic [HALF_W-1:0] dmaRdata;

    stepT              steps[$];
    logic [DATA_W-1:0] refMem [CHIP_WORDS];
    logic [31:0]       rngState = 32'd95;
    int                errors = 0;
    int                cycleCount = 0;
    int                cycleLimit;

    u712ChipRamTop DUT (
        .clk      (clk),
        .rstN     (rstN),
        .ts       (ts),
        .cpuReq   (cpuReq),
        .ta       (ta),
        .cpuRdata (cpuRdata),
        .dmaStart (dmaStart),
        .dmaReq   (dmaReq),
        .dmaDone  (dmaDone),
        .dmaRdata (dmaRdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    // Xorshift32 generator for write data
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Mask bit 3 is the most significant byte, which is offset 0 on the 68040
    function automatic logic [3:0] cpuLaneMask(input sizeE siz, input logic [1:0] a);
        if (siz == SIZ_BYTE) begin
            return 4'b1000 >> a;
        end
        if (siz == SIZ_WORD) begin
            return a[1] ? 4'b0011 : 4'b1100;
        end
        return 4'b1111;
    endfunction

    // The strobe pair lands on the half picked by dbEn, casU on its high byte
    function automatic logic [3:0] dmaLaneMask(input logic casU, input logic casL,
                                               input logic dbEn);
        return dbEn ? {casU, casL, 2'b00} : {2'b00, casU, casL};
    endfunction

    function automatic void applyWrite(input logic [CHIP_ADDR_W-1:0] addr,
                                       input logic [3:0] mask, input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                refMem[addr][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checking and sequencing helpers
    //////////////////////////////////////////////////////////////////////

    task automatic checkValue(input logic [31:0] got, input logic [31:0] expected,
                              input string what);
        if (got !== expected) begin
            errors++;
            $display("Mismatch at %0t: %s, got %h expected %h", $time, what, got, expected);
        end
    endtask

    // Strobes are packed as {casU, casL, dbEn}
    task automatic addStep(input opE op, input logic isDma, input logic [7:0] addr,
                           input logic [1:0] a, input sizeE siz, input logic [2:0] strobes,
                           input logic [31:0] data);
        steps.push_back('{op: op, isDma: isDma, addr: addr, a: a, siz: siz,
                          casU: strobes[2], casL: strobes[1], dbEn: strobes[0], data: data});
    endtask

    // Counts falling edges from the one after the start pulse until the acknowledge
    task automatic waitAck(input logic forDma, output int lat);
        lat = 0;
        while (!(forDma ? dmaDone : ta)) begin
            @(negedge clk);
            lat++;
        end
    endtask

    task automatic runStep(input int idx);
        stepT  s;
        int    lat;
        int    dmaAt;
        int    taAt;
        string tag;
        s = steps[idx];
        tag = $sformatf("step %0d", idx);
        cpuReq = '{addr: s.addr, a: s.a, siz: s.siz, rnw: (s.op == OP_READ), wdata: s.data};
        dmaReq = '{addr: s.addr, rnw: (s.op == OP_READ), casU: s.casU, casL: s.casL,
                   dbEn: s.dbEn, wdata: s.data[15:0]};
        if (s.op == OP_COLLIDE) begin
            ts = 1'b1;
            dmaStart = 1'b1;
            @(negedge clk);
            ts = 1'b0;
            dmaStart = 1'b0;
            lat = 0;
            dmaAt = -1;
            taAt = -1;
            while (taAt < 0) begin
                @(negedge clk);
                lat++;
                if (dmaDone) dmaAt = lat;
                if (ta) taAt = lat;
            end
            checkValue(32'(dmaAt >= 0 && dmaAt < taAt), 32'd1, {tag, " dmaDone before ta"});
            checkValue(taAt, 4, {tag, " ta latency on collision"});
            // DMA wins arbitration, so the CPU bytes land on top
            applyWrite(s.addr, dmaLaneMask(s.casU, s.casL, s.dbEn),
                       {s.data[15:0], s.data[15:0]});
            applyWrite(s.addr, cpuLaneMask(s.siz, s.a), s.data);
        end else begin
            if (s.isDma) dmaStart = 1'b1;
            else ts = 1'b1;
            @(negedge clk);
            ts = 1'b0;
            dmaStart = 1'b0;
            waitAck(s.isDma, lat);
            checkValue(lat, 2, {tag, " acknowledge latency"});
            if (s.op == OP_READ && s.isDma) begin
                checkValue(32'(dmaRdata), s.dbEn ? 32'(refMem[s.addr][31:16])
                                                 : 32'(refMem[s.addr][15:0]),
                           {tag, " DMA read half"});
            end else if (s.op == OP_READ) begin
                checkValue(cpuRdata, refMem[s.addr], {tag, " CPU read word"});
            end else if (s.isDma) begin
                applyWrite(s.addr, dmaLaneMask(s.casU, s.casL, s.dbEn),
                           {s.data[15:0], s.data[15:0]});
            end else begin
                applyWrite(s.addr, cpuLaneMask(s.siz, s.a), s.data);
            end
        end
    endtask

    task automatic buildTable();
        // Long and line writes, each read back in full
        addStep(OP_WRITE, MASTER_CPU, 8'h10, 2'd0, SIZ_LONG, 3'b000, nextRandom());
        addStep(OP_READ,  MASTER_CPU, 8'h10, 2'd0, SIZ_LONG, 3'b000, 32'h0);
        addStep(OP_WRITE, MASTER_CPU, 8'h11, 2'd0, SIZ_LINE, 3'b000, nextRandom());
        addStep(OP_READ,  MASTER_CPU, 8'h11, 2'd0, SIZ_LONG, 3'b000, 32'h0);
        // Byte writes walk all four offsets over one known word
        addStep(OP_WRITE, MASTER_CPU, 8'h30, 2'd0, SIZ_LONG, 3'b000, nextRandom());
        for (int k = 0; k < 4; k++) begin
            addStep(OP_WRITE, MASTER_CPU, 8'h30, 2'(k), SIZ_BYTE, 3'b000, nextRandom());
            addStep(OP_READ,  MASTER_CPU, 8'h30, 2'd0, SIZ_LONG, 3'b000, 32'h0);
        end
        // Word writes to each half
        addStep(OP_WRITE, MASTER_CPU, 8'h40, 2'd0, SIZ_LONG, 3'b000, nextRandom());
        addStep(OP_WRITE, MASTER_CPU, 8'h40, 2'd0, SIZ_WORD, 3'b000, nextRandom());
        addStep(OP_READ,  MASTER_CPU, 8'h40, 2'd0, SIZ_LONG, 3'b000, 32'h0);
        addStep(OP_WRITE, MASTER_CPU, 8'h40, 2'd2, SIZ_WORD, 3'b000, nextRandom());
        addStep(OP_READ,  MASTER_CPU, 8'h40, 2'd0, SIZ_LONG, 3'b000, 32'h0)
        ;
        // Every strobe combination, each on its own freshly written word
        for (int k = 0; k < 8; k++) begin
            addStep(OP_WRITE, MASTER_CPU, 8'h20 + 8'(k), 2'd0, SIZ_LONG, 3'b000, nextRandom());
            addStep(OP_WRITE, MASTER_DMA, 8'h20 + 8'(k), 2'd0, SIZ_LONG, 3'(k), nextRandom());
            addStep(OP_READ,  MASTER_CPU, 8'h20 + 8'(k), 2'd0, SIZ_LONG, 3'b000, 32'h0);
            addStep(OP_READ,  MASTER_DMA, 8'h20 + 8'(k), 2'd0, SIZ_LONG, 3'(k), 32'h0);
        end
        // DMA upper half and a CPU byte that overlaps it on the same edge
        addStep(OP_WRITE,   MASTER_CPU, 8'h50, 2'd0, SIZ_LONG, 3'b000, nextRandom());
        addStep(OP_COLLIDE, MASTER_CPU, 8'h50, 2'd1, SIZ_BYTE, 3'b111, nextRandom());
        addStep(OP_READ,    MASTER_CPU, 8'h50, 2'd0, SIZ_LONG, 3'b000, 32'h0);
        addStep(OP_READ,    MASTER_DMA, 8'h50, 2'd0, SIZ_LONG, 3'b111, 32'h0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Watchdog and main sequence
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    initial begin
        rstN = 1'b0;
        ts = 1'b0;
        dmaStart = 1'b0;
        cpuReq = '0;
        dmaReq = '0;
        buildTable();
        // Each step needs at most about six cycles
        cycleLimit = steps.size() * 8 + RESET_CYCLES + 20;
        repeat (RESET_CYCLES) @(negedge clk);
        rstN = 1'b1;
        // No acknowledge may show up before the first request
        repeat (3) begin
            @(negedge clk);
            checkValue(32'(ta), 32'd0, "ta idle after reset");
            checkValue(32'(dmaDone), 32'd0, "dmaDone idle after reset");
        end
        for (int i = 0; i < steps.size(); i++) begin
            runStep(i);
            @(negedge clk);
        end
        $display("Errors: %0d in %0d steps", errors, steps.size());
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
rtl/u712Pkg.sv
rtl/byteEnable.sv
rtl/chipRamSequencer.sv
rtl/chipRamArray.sv
rtl/u712ChipRamTop.sv
dv/u712ChipRamTb.sv

// File: run.sh
#!/bin/sh
# Builds the chip RAM testbench with Verilator and runs it.
# The exit status is zero only when the pass line appears in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/1ps \
    -f filelist.f \
    --top-module u712ChipRamTb \
    -o u712ChipRamSim

output=$(./obj_dir/u712ChipRamSim)
echo "$output"

if echo "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
else
    exit 1
fi
